// File: design/video_cfg.svh
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

//////////////////////////////////////////////////////////////////////
// horizontal raster, counted in pixel strobes
//////////////////////////////////////////////////////////////////////

// visible pixels per line
`define H_ACTIVE 640
// first pixel with hsync low
`define H_SYNC_START 656
// first pixel with hsync high again
`define H_SYNC_END 752
`define H_TOTAL 800

//////////////////////////////////////////////////////////////////////
// vertical raster, counted in lines
//////////////////////////////////////////////////////////////////////

`define V_ACTIVE 480
// first line with vsync low
`define V_SYNC_START 491
`define V_SYNC_END 493
// one line short of the usual 525
`define V_TOTAL 524

// coordinate counter width
`define COORD_W 11

// step for brighten, darken and the reduce modes
`define ADJUST_VALUE 8

`endif

// File: design/raster_pkg.sv
`include "video_cfg.svh"

package raster_pkg;

   // screen position of the pixel being scanned
   typedef struct packed {
      logic [`COORD_W-1:0] h_pos;
      logic [`COORD_W-1:0] v_pos;
   } raster_pos_t;

   // sync is active low, blank is active high
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic hblank;
      logic vblank;
   } raster_ctrl_t;

endpackage

// File: design/pixel_pkg.sv
package pixel_pkg;

   // incoming pixel, 8 bits per channel
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb888_t;

   // pixel on the VGA connector, 4 bits per channel
   typedef struct packed {
      logic [3:0] red;
      logic [3:0] green;
      logic [3:0] blue;
   } rgb444_t;

   // colour operation applied to each pixel
   typedef enum logic [2:0] {
      filter_gray         = 3'd0,
      filter_brighten     = 3'd1,
      filter_darken       = 3'd2,
      filter_invert       = 3'd3,
      filter_red_reduce   = 3'd4,
      filter_blue_reduce  = 3'd5,
      filter_green_reduce = 3'd6,
      filter_passthrough  = 3'd7
   } filter_mode_e;

endpackage

// File: design/raster_timing.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module raster_timing import raster_pkg::*; (
   input  logic         clock,
   input  logic         reset,
   output raster_pos_t  pos_o,
   output raster_ctrl_t ctrl_o,
   output logic         strobe_o,
   output logic         blank_o
);

   // events fire on the strobe where the counter sits one before the edge
   localparam logic [`COORD_W-1:0] h_last     = `COORD_W'(`H_TOTAL - 1);
   localparam logic [`COORD_W-1:0] h_blank_at = `COORD_W'(`H_ACTIVE - 1);
   localparam logic [`COORD_W-1:0] h_sync_on  = `COORD_W'(`H_SYNC_START - 1);
   localparam logic [`COORD_W-1:0] h_sync_off = `COORD_W'(`H_SYNC_END - 1);
   localparam logic [`COORD_W-1:0] v_last     = `COORD_W'(`V_TOTAL - 1);
   localparam logic [`COORD_W-1:0] v_blank_at = `COORD_W'(`V_ACTIVE - 1);
   localparam logic [`COORD_W-1:0] v_sync_on  = `COORD_W'(`V_SYNC_START - 1);
   localparam logic [`COORD_W-1:0] v_sync_off = `COORD_W'(`V_SYNC_END - 1);

   logic         phase_q;
   logic         h_wrap;
   logic         v_wrap;
   raster_pos_t  pos_q;
   raster_ctrl_t ctrl_q;

   //////////////////////////////////////////////////////////////////////
   // pixel strobe, clock divided by two
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         phase_q <= 1'b1;
      end else begin
         phase_q <= ~phase_q;
      end
   end

   // first strobe lands in the cycle after reset falls
   assign strobe_o = phase_q & ~reset;

   assign h_wrap = strobe_o & (pos_q.h_pos == h_last);
   assign v_wrap = h_wrap & (pos_q.v_pos == v_last);

   //////////////////////////////////////////////////////////////////////
   // position counters
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         pos_q <= '0;
      end else begin
         if (strobe_o) begin
            pos_q.h_pos <= h_wrap ? '0 : pos_q.h_pos + 1'b1;
         end
         if (h_wrap) begin
            pos_q.v_pos <= v_wrap ? '0 : pos_q.v_pos + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // sync and blank, set/clear on counter positions
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         ctrl_q.hsync  <= 1'b1;
         ctrl_q.vsync  <= 1'b1;
         ctrl_q.hblank <= 1'b0;
         ctrl_q.vblank <= 1'b0;
      end else begin
         if (h_wrap) begin
            ctrl_q.hblank <= 1'b0;
         end else if (strobe_o && pos_q.h_pos == h_blank_at) begin
            ctrl_q.hblank <= 1'b1;
         end
         if (strobe_o && pos_q.h_pos == h_sync_on) begin
            ctrl_q.hsync <= 1'b0;
         end else if (strobe_o && pos_q.h_pos == h_sync_off) begin
            ctrl_q.hsync <= 1'b1;
         end
         // vertical events only move at the end of a line
         if (v_wrap) begin
            ctrl_q.vblank <= 1'b0;
         end else if (h_wrap && pos_q.v_pos == v_blank_at) begin
            ctrl_q.vblank <= 1'b1;
         end
         if (h_wrap && pos_q.v_pos == v_sync_on) begin
            ctrl_q.vsync <= 1'b0;
         end else if (h_wrap && pos_q.v_pos == v_sync_off) begin
            ctrl_q.vsync <= 1'b1;
         end
      end
   end

   assign pos_o   = pos_q;
   assign ctrl_o  = ctrl_q;
   assign blank_o = ctrl_q.hblank | ctrl_q.vblank;

   // counters never leave the frame
   a_pos_range: assert property (@(posedge clock) disable iff (reset)
      (pos_q.h_pos < `H_TOTAL) && (pos_q.v_pos < `V_TOTAL));

   // strobe is a single-cycle pulse every other clock
   a_strobe_gap: assert property (@(posedge clock) disable iff (reset)
      strobe_o |=> !strobe_o);

endmodule

// File: design/point_filter.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module point_filter import raster_pkg::*, pixel_pkg::*; (
   input  logic         clock,
   input  logic         reset,
   input  logic         strobe_i,
   input  logic         blank_i,
   input  filter_mode_e mode_i,
   input  rgb888_t      pixel_i,
   output rgb444_t      pixel_o
);

   localparam logic [7:0] adjust = 8'(`ADJUST_VALUE);
   localparam logic [`COORD_W-1:0] h_last = `COORD_W'(`H_TOTAL - 1);
   localparam logic [`COORD_W-1:0] v_last = `COORD_W'(`V_TOTAL - 1);

   logic [7:0]  luma;
   rgb888_t     filtered;
   rgb444_t     pixel_q;
   raster_pos_t shadow_q;

   // brighten one channel, clamp at white
   function automatic logic [7:0] sat_add(input logic [7:0] chan);
      logic [8:0] sum;
      sum = {1'b0, chan} + {1'b0, adjust};
      return sum[8] ? 8'hff : sum[7:0];
   endfunction

   // darken one channel, clamp at black
   function automatic logic [7:0] sat_sub(input logic [7:0] chan);
      return (chan < adjust) ? 8'h00 : chan - adjust;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // colour operations on 8-bit channels
   //////////////////////////////////////////////////////////////////////

   // shift-add luma approximation, tops out at 234
   assign luma = (pixel_i.red >> 2) + (pixel_i.red >> 5)
               + (pixel_i.green >> 1) + (pixel_i.green >> 4)
               + (pixel_i.blue >> 4) + (pixel_i.blue >> 5);

   always_comb begin
      filtered = pixel_i;
      case (mode_i)
         filter_gray: begin
            filtered.red   = luma;
            filtered.green = luma;
            filtered.blue  = luma;
         end
         filter_brighten: begin
            filtered.red   = sat_add(pixel_i.red);
            filtered.green = sat_add(pixel_i.green);
            filtered.blue  = sat_add(pixel_i.blue);
         end
         filter_darken: begin
            filtered.red   = sat_sub(pixel_i.red);
            filtered.green = sat_sub(pixel_i.green);
            filtered.blue  = sat_sub(pixel_i.blue);
         end
         filter_invert: begin
            filtered.red   = 8'hff - pixel_i.red;
            filtered.green = 8'hff - pixel_i.green;
            filtered.blue  = 8'hff - pixel_i.blue;
         end
         // reduce modes darken a single channel
         filter_red_reduce:   filtered.red   = sat_sub(pixel_i.red);
         filter_blue_reduce:  filtered.blue  = sat_sub(pixel_i.blue);
         filter_green_reduce: filtered.green = sat_sub(pixel_i.green);
         filter_passthrough:  filtered = pixel_i;
         default:             filtered = pixel_i;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // quantize to 4 bits and register on the strobe
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         pixel_q <= '0;
      end else if (strobe_i) begin
         if (blank_i) begin
            pixel_q <= '0;
         end else begin
            pixel_q.red   <= filtered.red[7:4];
            pixel_q.green <= filtered.green[7:4];
            pixel_q.blue  <= filtered.blue[7:4];
         end
      end
   end

   assign pixel_o = pixel_q;

   // position implied by the strobe count, for checking blank
   always_ff @(posedge clock) begin
      if (reset) begin
         shadow_q <= '0;
      end else if (strobe_i) begin
         if (shadow_q.h_pos == h_last) begin
            shadow_q.h_pos <= '0;
            shadow_q.v_pos <= (shadow_q.v_pos == v_last) ? '0 : shadow_q.v_pos + 1'b1;
         end else begin
            shadow_q.h_pos <= shadow_q.h_pos + 1'b1;
         end
      end
   end

   a_blank_zero: assert property (@(posedge clock) disable iff (reset)
      strobe_i && blank_i |=> pixel_o == '0);

   a_hold: assert property (@(posedge clock) disable iff (reset)
      !strobe_i |=> $stable(pixel_o));

   // blank from the timing block matches the visible window
   a_blank_window: assert property (@(posedge clock) disable iff (reset)
      strobe_i |-> blank_i == ((shadow_q.h_pos >= `H_ACTIVE) ||
                               (shadow_q.v_pos >= `V_ACTIVE)));

endmodule

// File: design/video_filter_top.sv
`timescale 1ns/1ns

module video_filter_top import raster_pkg::*, pixel_pkg::*; (
   input  logic         clock,
   input  logic         reset,
   input  filter_mode_e mode_i,
   input  rgb888_t      pixel_i,
   output rgb444_t      pixel_o,
   output raster_pos_t  pos_o,
   output raster_ctrl_t ctrl_o
);

   // pixel strobe and combined blank from the raster
   logic strobe;
   logic blank;

   //////////////////////////////////////////////////////////////////////
   // raster generator
   //////////////////////////////////////////////////////////////////////

   raster_timing u_timing (
      .clock    (clock),
      .reset    (reset),
      .pos_o    (pos_o),
      .ctrl_o   (ctrl_o),
      .strobe_o (strobe),
      .blank_o  (blank)
   );

   //////////////////////////////////////////////////////////////////////
   // colour filter, one pixel per strobe
   //////////////////////////////////////////////////////////////////////

   point_filter u_filter (
      .clock    (clock),
      .reset    (reset),
      .strobe_i (strobe),
      .blank_i  (blank),
      .mode_i   (mode_i),
      .pixel_i  (pixel_i),
      .pixel_o  (pixel_o)
   );

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
   output logic clock_o,
   output logic reset_o
);

   // 4 ns period
   initial begin
      clock_o = 1'b0;
      forever #2 clock_o = ~clock_o;
   end

   // reset held for 8 cycles, released on a falling edge
   initial begin
      reset_o = 1'b1;
      repeat (8) @(posedge clock_o);
      @(negedge clock_o);
      reset_o <= 1'b0;
   end

endmodule

// File: tests/tb_video_filter.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module tb_video_filter import raster_pkg::*, pixel_pkg::*;;

   localparam logic [`COORD_W-1:0] h_active = `COORD_W'(`H_ACTIVE);
   localparam logic [`COORD_W-1:0] h_sync_a = `COORD_W'(`H_SYNC_START);
   localparam logic [`COORD_W-1:0] h_sync_b = `COORD_W'(`H_SYNC_END);
   localparam logic [`COORD_W-1:0] v_active = `COORD_W'(`V_ACTIVE);
   localparam logic [`COORD_W-1:0] v_sync_a = `COORD_W'(`V_SYNC_START);
   localparam logic [`COORD_W-1:0] v_sync_b = `COORD_W'(`V_SYNC_END);
   localparam logic [`COORD_W-1:0] v_last   = `COORD_W'(`V_TOTAL - 1);
   // one frame is 838,400 clocks, the whole run stays well under 2.4 frames
   localparam int timeout_cycles = 2_000_000;

   logic         clock;
   logic         reset;
   filter_mode_e mode_i;
   rgb888_t      pixel_i;
   rgb444_t      pixel_o;
   raster_pos_t  pos_o;
   raster_ctrl_t ctrl_o;
   logic [31:0]  lfsr_state = 32'd67420;
   int           cycle_count = 0;

   clock_gen u_clock (.clock_o(clock), .reset_o(reset));

   video_filter_top UUT (
      .clock   (clock),
      .reset   (reset),
      .mode_i  (mode_i),
      .pixel_i (pixel_i),
      .pixel_o (pixel_o),
      .pos_o   (pos_o),
      .ctrl_o  (ctrl_o)
   );

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Test failed");
      $fatal(1, "simulation stopped");
   endtask

   always @(posedge clock) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         abort_run("timeout: the tests did not finish within the cycle limit");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus source and reference model
   //////////////////////////////////////////////////////////////////////

   // galois lfsr, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   task automatic next_pixel(output rgb888_t p);
      p = '0;
      for (int i = 0; i < 24; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         p = {p[22:0], lfsr_state[0]};
      end
   endtask

   function automatic int clamp8(input int v);
      return (v < 0) ? 0 : ((v > 255) ? 255 : v);
   endfunction

   function automatic rgb444_t expect_pixel(input filter_mode_e mode, input rgb888_t p,
                                            input raster_pos_t at);
      int r;
      int g;
      int b;
      int y;
      rgb444_t q;
      r = int'(p.red);
      g = int'(p.green);
      b = int'(p.blue);
      y = r / 4 + r / 32 + g / 2 + g / 16 + b / 16 + b / 32;
      case (mode)
         filter_gray: begin
            r = y;
            g = y;
            b = y;
         end
         filter_brighten: begin
            r = clamp8(r + `ADJUST_VALUE);
            g = clamp8(g + `ADJUST_VALUE);
            b = clamp8(b + `ADJUST_VALUE);
         end
         filter_darken: begin
            r = clamp8(r - `ADJUST_VALUE);
            g = clamp8(g - `ADJUST_VALUE);
            b = clamp8(b - `ADJUST_VALUE);
         end
         filter_invert: begin
            r = 255 - r;
            g = 255 - g;
            b = 255 - b;
         end
         filter_red_reduce:   r = clamp8(r - `ADJUST_VALUE);
         filter_blue_reduce:  b = clamp8(b - `ADJUST_VALUE);
         filter_green_reduce: g = clamp8(g - `ADJUST_VALUE);
         default: ;
      endcase
      q.red   = r[7:4];
      q.green = g[7:4];
      q.blue  = b[7:4];
      if (at.h_pos >= h_active || at.v_pos >= v_active) begin
         q = '0;
      end
      return q;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // helpers, all called on a falling edge
   //////////////////////////////////////////////////////////////////////

   // hold one pixel until the raster moves on, at is where it was taken
   task automatic drive_pixel(input filter_mode_e mode, input rgb888_t p,
                              output raster_pos_t at);
      mode_i  = mode;
      pixel_i = p;
      at      = pos_o;
      @(negedge clock);
      while (pos_o == at) @(negedge clock);
   endtask

   task automatic wait_h_entry(input logic [`COORD_W-1:0] h);
      logic [`COORD_W-1:0] last;
      last = pos_o.h_pos;
      @(negedge clock);
      while (!(pos_o.h_pos == h && last != h)) begin
         last = pos_o.h_pos;
         @(negedge clock);
      end
   endtask

   task automatic check_idle_outputs(input logic [`COORD_W-1:0] h);
      assert (pixel_o == '0 && pos_o.h_pos == h && pos_o.v_pos == '0 && ctrl_o.hsync &&
              ctrl_o.vsync && !ctrl_o.hblank && !ctrl_o.vblank)
      else abort_run($sformatf("** Error at %0t ns: reset state wrong, pos %0d/%0d ctrl %b",
                               $time, pos_o.h_pos, pos_o.v_pos, ctrl_o));
   endtask

   task automatic check_ctrl_vs_pos();
      logic hs;
      logic vs;
      hs = !(pos_o.h_pos >= h_sync_a && pos_o.h_pos < h_sync_b);
      vs = !(pos_o.v_pos >= v_sync_a && pos_o.v_pos < v_sync_b);
      assert (ctrl_o.hsync == hs && ctrl_o.vsync == vs &&
              ctrl_o.hblank == (pos_o.h_pos >= h_active) &&
              ctrl_o.vblank == (pos_o.v_pos >= v_active))
      else abort_run($sformatf("** Error at %0t ns: ctrl %b does not match pos %0d/%0d",
                               $time, ctrl_o, pos_o.h_pos, pos_o.v_pos));
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic check_reset_state();
      @(negedge clock);
      while (reset) begin
         check_idle_outputs('0);
         @(negedge clock);
      end
      // first strobe already moved the column
      check_idle_outputs(`COORD_W'(1));
   endtask

   task automatic check_line_timing();
      int clocks;
      int low_clocks;
      logic last_sync;
      logic [`COORD_W-1:0] last_h;
      wait_h_entry(`COORD_W'(1));
      clocks     = 0;
      low_clocks = 0;
      last_sync  = ctrl_o.hsync;
      last_h     = pos_o.h_pos;
      @(negedge clock);
      while (!(pos_o.h_pos == `COORD_W'(1) && last_h != `COORD_W'(1))) begin
         clocks++;
         if (!ctrl_o.hsync) low_clocks++;
         if (last_sync && !ctrl_o.hsync) begin
            assert (pos_o.h_pos == h_sync_a)
            else abort_run($sformatf("** Error at %0t ns: hsync fell at column %0d",
                                     $time, pos_o.h_pos));
         end
         last_sync = ctrl_o.hsync;
         last_h    = pos_o.h_pos;
         @(negedge clock);
      end
      clocks++;
      assert (clocks == 1600 && low_clocks == 192)
      else abort_run($sformatf("** Error at %0t ns: line %0d clocks, hsync low %0d clocks",
                               $time, clocks, low_clocks));
   endtask

   task automatic check_frame_timing();
      logic [`COORD_W-1:0] last_v;
      logic wrapped;
      wrapped = 1'b0;
      last_v  = pos_o.v_pos;
      while (!wrapped) begin
         @(negedge clock);
         check_ctrl_vs_pos();
         if (pos_o.v_pos != last_v) begin
            assert (pos_o.v_pos == last_v + `COORD_W'(1) ||
                    (last_v == v_last && pos_o.v_pos == '0))
            else abort_run($sformatf("** Error at %0t ns: line stepped from %0d to %0d",
                                     $time, last_v, pos_o.v_pos));
            wrapped = (last_v == v_last);
         end
         last_v = pos_o.v_pos;
      end
   endtask

   // the frame test leaves the raster at the top-left pixel
   task automatic check_point_modes();
      rgb888_t p;
      raster_pos_t at;
      rgb444_t want;
      for (int m = 0; m < 8; m++) begin
         for (int n = 0; n < 40; n++) begin
            next_pixel(p);
            drive_pixel(filter_mode_e'(m[2:0]), p, at);
            want = expect_pixel(filter_mode_e'(m[2:0]), p, at);
            assert (pixel_o == want)
            else abort_run($sformatf("** Error at %0t ns: mode %0d in %h got %h expected %h",
                                     $time, m, p, pixel_o, want));
         end
      end
   endtask

   task automatic check_saturation_and_blank();
      raster_pos_t at;
      rgb888_t p;
      drive_pixel(filter_brighten, 24'hfa_fa_fa, at);
      assert (pixel_o == 12'hfff)
      else abort_run($sformatf("** Error at %0t ns: brighten gave %h", $time, pixel_o));
      drive_pixel(filter_darken, 24'h05_05_05, at);
      assert (pixel_o == 12'h000)
      else abort_run($sformatf("** Error at %0t ns: darken gave %h", $time, pixel_o));
      drive_pixel(filter_red_reduce, 24'h03_a7_5c, at);
      assert (pixel_o == 12'h0a5)
      else abort_run($sformatf("** Error at %0t ns: red reduce gave %h", $time, pixel_o));
      // right border, every mode must give black
      wait_h_entry(h_active);
      for (int m = 0; m < 8; m++) begin
         next_pixel(p);
         drive_pixel(filter_mode_e'(m[2:0]), p | 24'h80_80_80, at);
         assert (at.h_pos >= h_active && pixel_o == '0)
         else abort_run($sformatf("** Error at %0t ns: column %0d mode %0d gave %h",
                                  $time, at.h_pos, m, pixel_o));
      end
   endtask

   initial begin
      mode_i  = filter_passthrough;
      pixel_i = '0;
      check_reset_state();
      check_line_timing();
      check_frame_timing();
      check_point_modes();
      check_saturation_and_blank();
      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: files.f
+incdir+design
design/raster_pkg.sv
design/pixel_pkg.sv
design/raster_timing.sv
design/point_filter.sv
design/video_filter_top.sv
tests/clock_gen.sv
tests/tb_video_filter.sv

// File: run.sh
#!/bin/sh
# build and run the VGA filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f files.f \
   --top-module tb_video_filter \
   -Mdir obj_dir

./obj_dir/Vtb_video_filter
